/* design/rp_adc_front.sv */
// ADC input stage of both channels
// keeps the top 14 of 16 pin bits, turns the negative-slope code into
// two's complement and optionally swaps in the digital loop value
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_adc_front (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  logic [`RP_ADC_RAW_W-1:0] adc_a_dat_i,
  input  logic [`RP_ADC_RAW_W-1:0] adc_b_dat_i,
  input  logic                     digital_loop_i,
  input  rp_pkg::sample_vec_t      loop_dat_i,     // limiter register output
  output rp_pkg::sample_vec_t      smp_o
);

  logic [`RP_SMP_W-1:0] raw_q [`RP_CHN];  // pin code, lowest 2 bits dropped
  rp_pkg::sample_vec_t  conv_w;

  // IO register, one cycle of the path latency
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_q[0] <= {1'b0, {(`RP_SMP_W-1){1'b1}}};   // code of sample 0
      raw_q[1] <= {1'b0, {(`RP_SMP_W-1){1'b1}}};
    end
    else
    begin
      raw_q[0] <= adc_a_dat_i[`RP_ADC_RAW_W-1 -: `RP_SMP_W];
      raw_q[1] <= adc_b_dat_i[`RP_ADC_RAW_W-1 -: `RP_SMP_W];
    end
  end

  // negative slope to two's complement, sign kept and the rest inverted
  always_comb
  begin
    for (int ch = 0; ch < `RP_CHN; ch++)
      conv_w[ch] = {raw_q[ch][`RP_SMP_W-1], ~raw_q[ch][`RP_SMP_W-2:0]};
  end

  assign smp_o = digital_loop_i ? loop_dat_i : conv_w;  // no extra delay

endmodule

/* design/rp_defs.svh */
// widths, channel count and register map of the fast analog path
// include wherever a macro below is used; the include guard allows repeats
// register words inside a region are group * RP_CHN + channel
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

`define RP_CHN        2            // analog channels
`define RP_ADC_RAW_W  16           // ADC pin width
`define RP_SMP_W      14           // sample width after the cut
`define RP_ADDR_W     20           // bus address width, counts words
`define RP_DATA_W     32           // bus data width
`define RP_REGION_HI  19           // region select field
`define RP_REGION_LO  16
`define RP_REG_HK     0            // housekeeping region
`define RP_REG_CTRL   1            // controller region
`define RP_REG_LIM    2            // limiter region
`define RP_ID_VALUE   32'h5250_0a01
`define RP_GAIN_SHIFT 8            // product >>> shift, gain 256 is unity

`define RP_HK_ID      0            // identification, read only
`define RP_HK_LOOP    1            // bit 0 selects the digital loop
`define RP_CT_SET     0            // setpoint group
`define RP_CT_GAIN    1            // gain group
`define RP_CT_BIAS    2            // bias group
`define RP_LM_MIN     0            // lower limit group
`define RP_LM_MAX     1            // upper limit group
`define RP_LM_RAIL    4            // railed flags, plain word

`endif

/* design/rp_housekeeping.sv */
// housekeeping registers in region RP_REG_HK
// read-only identification word and the digital loop control bit
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_housekeeping (
  input  logic     adc_clk,
  input  logic     rst_i,
  sys_bus_if.slave bus,
  output logic     digital_loop_o   // 1 feeds the limiter output back
);

  logic [`RP_REGION_LO-1:0] off;      // word inside the region
  logic                     wr_stb;   // first cycle of a write
  logic                     rd_stb;   // first cycle of a read
  rp_pkg::bus_word_t        rd_word;

  assign off     = bus.addr[`RP_REGION_LO-1:0];
  assign wr_stb  = bus.wen & ~bus.ack;
  assign rd_stb  = bus.ren & ~bus.ack;
  assign bus.err = 1'b0;              // every word here is readable

  always_comb
  begin
    rd_word = '0;                     // undefined words read zero
    if (off == `RP_HK_ID)
      rd_word = `RP_ID_VALUE;
    if (off == `RP_HK_LOOP)
      rd_word[0] = digital_loop_o;
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      bus.ack        <= 1'b0;
      digital_loop_o <= 1'b0;         // loop off
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;   // rises and falls one clock late
      if (wr_stb && off == `RP_HK_LOOP)
        digital_loop_o <= bus.wdata[0];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rd_stb)
      bus.rdata <= rd_word;
  end

endmodule

/* design/rp_out_stage.sv */
// output stage of both channels, limiter registers in region RP_REG_LIM
// saturates the controller sum to 14 bits, clamps to min/max, keeps
// sticky railed flags and forms the negative-slope DAC code
// two register stages, limiter then DAC code
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_out_stage (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  input  rp_pkg::wide_t [`RP_CHN-1:0]  ctrl_i,
  sys_bus_if.slave                     bus,
  output rp_pkg::sample_vec_t          lim_o,        // also the loop value
  output logic [`RP_SMP_W-1:0]         dac_a_dat_o,
  output logic [`RP_SMP_W-1:0]         dac_b_dat_o
);

  // full 14-bit range
  localparam rp_pkg::wide_t sat_max = (32'sd1 <<< (`RP_SMP_W-1)) - 32'sd1;
  localparam rp_pkg::wide_t sat_min = -(32'sd1 <<< (`RP_SMP_W-1));

  rp_pkg::sample_t          min_q   [`RP_CHN];
  rp_pkg::sample_t          max_q   [`RP_CHN];
  rp_pkg::rail_t            rail_q  [`RP_CHN];   // sticky
  rp_pkg::sample_t          sat_w   [`RP_CHN];
  rp_pkg::sample_t          clamp_w [`RP_CHN];
  rp_pkg::rail_t            hit_w   [`RP_CHN];   // clamped this cycle
  logic [`RP_SMP_W-1:0]     dac_q   [`RP_CHN];
  logic [`RP_REGION_LO-1:0] off;
  logic                     wr_stb;
  logic                     rd_stb;
  rp_pkg::bus_word_t        rd_word;

  assign off     = bus.addr[`RP_REGION_LO-1:0];
  assign wr_stb  = bus.wen & ~bus.ack;
  assign rd_stb  = bus.ren & ~bus.ack;
  assign bus.err = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // saturation and limiting
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < `RP_CHN; ch++)
    begin
      if (ctrl_i[ch] > sat_max)
        sat_w[ch] = sat_max[`RP_SMP_W-1:0];
      else if (ctrl_i[ch] < sat_min)
        sat_w[ch] = sat_min[`RP_SMP_W-1:0];
      else
        sat_w[ch] = ctrl_i[ch][`RP_SMP_W-1:0];
      clamp_w[ch] = sat_w[ch];
      hit_w[ch]   = 2'b00;
      if (sat_w[ch] > max_q[ch])
      begin
        clamp_w[ch] = max_q[ch];
        hit_w[ch]   = 2'b10;            // above max
      end
      else if (sat_w[ch] < min_q[ch])
      begin
        clamp_w[ch] = min_q[ch];
        hit_w[ch]   = 2'b01;            // below min
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      bus.ack <= 1'b0;
      for (int ch = 0; ch < `RP_CHN; ch++)
      begin
        min_q[ch]  <= {1'b1, {(`RP_SMP_W-1){1'b0}}};   // -8192
        max_q[ch]  <= {1'b0, {(`RP_SMP_W-1){1'b1}}};   // +8191
        rail_q[ch] <= '0;
        lim_o[ch]  <= '0;
        dac_q[ch]  <= {1'b0, {(`RP_SMP_W-1){1'b1}}};   // code of sample 0
      end
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;
      for (int ch = 0; ch < `RP_CHN; ch++)
      begin
        lim_o[ch] <= clamp_w[ch];
        dac_q[ch] <= {lim_o[ch][`RP_SMP_W-1], ~lim_o[ch][`RP_SMP_W-2:0]};
        if (wr_stb && off == `RP_LM_MIN * `RP_CHN + ch)
          min_q[ch] <= bus.wdata[`RP_SMP_W-1:0];
        if (wr_stb && off == `RP_LM_MAX * `RP_CHN + ch)
          max_q[ch] <= bus.wdata[`RP_SMP_W-1:0];
        if (wr_stb && off == `RP_LM_RAIL)
          rail_q[ch] <= '0;             // any write data clears
        else
          rail_q[ch] <= rail_q[ch] | hit_w[ch];
      end
    end
  end

  assign dac_a_dat_o = dac_q[0];
  assign dac_b_dat_o = dac_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // register read
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word = '0;
    for (int ch = 0; ch < `RP_CHN; ch++)
    begin
      if (off == `RP_LM_MIN * `RP_CHN + ch)
        rd_word = min_q[ch];            // sign-extended
      if (off == `RP_LM_MAX * `RP_CHN + ch)
        rd_word = max_q[ch];
      if (off == `RP_LM_RAIL)
        rd_word[2*ch +: 2] = rail_q[ch];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rd_stb)
      bus.rdata <= rd_word;
  end

endmodule

/* design/rp_p_ctrl.sv */
// two-channel proportional controller in region RP_REG_CTRL
// ctrl = bias + ((setpoint - input) * gain) >>> RP_GAIN_SHIFT, registered
// setpoint, gain and bias are per channel and read back sign-extended
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_p_ctrl (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  input  rp_pkg::sample_vec_t          smp_i,
  sys_bus_if.slave                     bus,
  output rp_pkg::wide_t [`RP_CHN-1:0]  ctrl_o
);

  rp_pkg::sample_t          set_q  [`RP_CHN];  // setpoint
  rp_pkg::gain_t            gain_q [`RP_CHN];  // 8.8 fixed point
  rp_pkg::sample_t          bias_q [`RP_CHN];  // offset added after scaling
  rp_pkg::wide_t            err_w  [`RP_CHN];
  rp_pkg::wide_t            prod_w [`RP_CHN];
  logic [`RP_REGION_LO-1:0] off;
  logic                     wr_stb;
  logic                     rd_stb;
  rp_pkg::bus_word_t        rd_word;

  assign off     = bus.addr[`RP_REGION_LO-1:0];
  assign wr_stb  = bus.wen & ~bus.ack;
  assign rd_stb  = bus.ren & ~bus.ack;
  assign bus.err = 1'b0;

  //////////////////////////////////////////////////////////////////////////
  // proportional path
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < `RP_CHN; ch++)
    begin
      err_w[ch]  = rp_pkg::wide_t'(set_q[ch]) - rp_pkg::wide_t'(smp_i[ch]);
      prod_w[ch] = err_w[ch] * rp_pkg::wide_t'(gain_q[ch]);  // fits 31 bits
    end
  end

  // output register, saturation waits for the next stage
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      ctrl_o <= '0;
    else
      for (int ch = 0; ch < `RP_CHN; ch++)
        ctrl_o[ch] <= rp_pkg::wide_t'(bias_q[ch]) + (prod_w[ch] >>> `RP_GAIN_SHIFT);
  end

  //////////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      bus.ack <= 1'b0;
      for (int ch = 0; ch < `RP_CHN; ch++)
      begin
        set_q[ch]  <= '0;
        gain_q[ch] <= '0;                   // output is the bias alone
        bias_q[ch] <= '0;
      end
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;
      for (int ch = 0; ch < `RP_CHN; ch++)
      begin
        if (wr_stb && off == `RP_CT_SET * `RP_CHN + ch)
          set_q[ch] <= bus.wdata[`RP_SMP_W-1:0];
        if (wr_stb && off == `RP_CT_GAIN * `RP_CHN + ch)
          gain_q[ch] <= bus.wdata[$bits(rp_pkg::gain_t)-1:0];
        if (wr_stb && off == `RP_CT_BIAS * `RP_CHN + ch)
          bias_q[ch] <= bus.wdata[`RP_SMP_W-1:0];
      end
    end
  end

  // signed fields extend on read
  always_comb
  begin
    rd_word = '0;
    for (int ch = 0; ch < `RP_CHN; ch++)
    begin
      if (off == `RP_CT_SET * `RP_CHN + ch)
        rd_word = set_q[ch];
      if (off == `RP_CT_GAIN * `RP_CHN + ch)
        rd_word = gain_q[ch];
      if (off == `RP_CT_BIAS * `RP_CHN + ch)
        rd_word = bias_q[ch];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rd_stb)
      bus.rdata <= rd_word;
  end

endmodule

/* design/rp_pkg.sv */
// shared types of the fast analog path
// modules reach them as rp_pkg::name, widths come from the macro header
`include "rp_defs.svh"

package rp_pkg;

  // one signed sample, ADC side after conversion or DAC side before it
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // all channels side by side, element 0 is channel a
  typedef sample_t [`RP_CHN-1:0] sample_vec_t;

  // controller sum, wide enough for the gain product
  typedef logic signed [31:0] wide_t;

  // proportional gain register
  typedef logic signed [15:0] gain_t;

  // railed status of one channel
  //   bit 1  clamped to the upper limit
  //   bit 0  clamped to the lower limit
  typedef logic [1:0] rail_t;

  // bus data word
  typedef logic [`RP_DATA_W-1:0] bus_word_t;

  // decoder phases
  typedef enum logic [1:0] {
    DEC_IDLE,   // waiting for a host request
    DEC_BUSY,   // request forwarded, waiting for the slave
    DEC_DONE    // ack to host, waiting for release
  } dec_phase_e;

endpackage

/* design/rp_top.sv */
// top of the two-channel fast analog path
// ADC pins -> front end -> P controller -> output stage -> DAC pins,
// 4 clocks pin to pin; the host bus configures everything behind one decoder
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  logic [`RP_ADC_RAW_W-1:0] adc_a_dat_i,
  input  logic [`RP_ADC_RAW_W-1:0] adc_b_dat_i,
  input  logic [`RP_ADDR_W-1:0]    bus_addr_i,
  input  logic [`RP_DATA_W-1:0]    bus_wdata_i,
  input  logic                     bus_wen_i,
  input  logic                     bus_ren_i,
  output logic [`RP_DATA_W-1:0]    bus_rdata_o,
  output logic                     bus_ack_o,
  output logic                     bus_err_o,
  output logic [`RP_SMP_W-1:0]     dac_a_dat_o,
  output logic [`RP_SMP_W-1:0]     dac_b_dat_o
);

  rp_pkg::sample_vec_t         smp;           // controller input
  rp_pkg::sample_vec_t         lim;           // limiter register, loop source
  rp_pkg::wide_t [`RP_CHN-1:0] ctrl;          // unsaturated controller sum
  logic                        digital_loop;

  sys_bus_if host_bus ();
  sys_bus_if hk_bus   ();
  sys_bus_if ctrl_bus ();
  sys_bus_if lim_bus  ();

  // host pins onto the bus
  assign host_bus.addr  = bus_addr_i;
  assign host_bus.wdata = bus_wdata_i;
  assign host_bus.wen   = bus_wen_i;
  assign host_bus.ren   = bus_ren_i;
  assign bus_rdata_o    = host_bus.rdata;
  assign bus_ack_o      = host_bus.ack;
  assign bus_err_o      = host_bus.err;

  //////////////////////////////////////////////////////////////////////////
  // bus decoder and housekeeping
  //////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .host    (host_bus),
    .hk      (hk_bus),
    .ctrl    (ctrl_bus),
    .lim     (lim_bus)
  );

  rp_housekeeping i_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (hk_bus),
    .digital_loop_o (digital_loop)
  );

  //////////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////////

  rp_adc_front i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_a_dat_i    (adc_a_dat_i),
    .adc_b_dat_i    (adc_b_dat_i),
    .digital_loop_i (digital_loop),
    .loop_dat_i     (lim),
    .smp_o          (smp)
  );

  rp_p_ctrl i_ctrl (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .smp_i   (smp),
    .bus     (ctrl_bus),
    .ctrl_o  (ctrl)
  );

  rp_out_stage i_out (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .ctrl_i      (ctrl),
    .bus         (lim_bus),
    .lim_o       (lim),
    .dac_a_dat_o (dac_a_dat_o),
    .dac_b_dat_o (dac_b_dat_o)
  );

endmodule

/* design/sys_bus_decoder.sv */
// splits the host bus into the housekeeping, controller and limiter regions
// region comes from address bits RP_REGION_HI..RP_REGION_LO
// one register stage each way, unmapped regions answer with err here
`timescale 1ns/1ns
`include "rp_defs.svh"

module sys_bus_decoder (
  input  logic      adc_clk,
  input  logic      rst_i,
  sys_bus_if.slave  host,
  sys_bus_if.master hk,
  sys_bus_if.master ctrl,
  sys_bus_if.master lim
);

  rp_pkg::dec_phase_e                   phase_q;
  logic [`RP_REGION_HI-`RP_REGION_LO:0] region_q;  // latched on accept
  logic [`RP_ADDR_W-1:0]                addr_q;
  rp_pkg::bus_word_t                    wdata_q;
  logic                                 wen_q;
  logic                                 ren_q;
  logic                                 host_req;
  logic                                 accept;
  logic                                 mapped;
  logic                                 slv_ack;
  logic                                 slv_err;
  rp_pkg::bus_word_t                    slv_rdata;

  assign host_req = host.wen | host.ren;
  assign mapped   = (region_q == `RP_REG_HK) || (region_q == `RP_REG_CTRL) ||
                    (region_q == `RP_REG_LIM);

  // accept only once the last slave has dropped ack
  assign accept = (phase_q == rp_pkg::DEC_IDLE) && host_req && !slv_ack;

  ////////////////////////////////////////////////////////////////////////////
  // forward side, shared address and data, request to one slave
  ////////////////////////////////////////////////////////////////////////////

  assign hk.addr    = addr_q;
  assign hk.wdata   = wdata_q;
  assign hk.wen     = wen_q && (region_q == `RP_REG_HK);
  assign hk.ren     = ren_q && (region_q == `RP_REG_HK);
  assign ctrl.addr  = addr_q;
  assign ctrl.wdata = wdata_q;
  assign ctrl.wen   = wen_q && (region_q == `RP_REG_CTRL);
  assign ctrl.ren   = ren_q && (region_q == `RP_REG_CTRL);
  assign lim.addr   = addr_q;
  assign lim.wdata  = wdata_q;
  assign lim.wen    = wen_q && (region_q == `RP_REG_LIM);
  assign lim.ren    = ren_q && (region_q == `RP_REG_LIM);

  // return path from the selected slave
  always_comb
  begin
    slv_ack   = 1'b0;                  // unmapped, nobody answers
    slv_err   = 1'b0;
    slv_rdata = '0;
    case (region_q)
      `RP_REG_HK:
      begin
        slv_ack   = hk.ack;
        slv_err   = hk.err;
        slv_rdata = hk.rdata;
      end
      `RP_REG_CTRL:
      begin
        slv_ack   = ctrl.ack;
        slv_err   = ctrl.err;
        slv_rdata = ctrl.rdata;
      end
      `RP_REG_LIM:
      begin
        slv_ack   = lim.ack;
        slv_err   = lim.err;
        slv_rdata = lim.rdata;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // phase machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      phase_q   <= rp_pkg::DEC_IDLE;
      region_q  <= '0;
      wen_q     <= 1'b0;
      ren_q     <= 1'b0;
      host.ack  <= 1'b0;
      host.err  <= 1'b0;
    end
    else
    begin
      case (phase_q)
        rp_pkg::DEC_IDLE:
          if (accept)
          begin
            region_q <= host.addr[`RP_REGION_HI:`RP_REGION_LO];
            wen_q    <= host.wen;
            ren_q    <= host.ren;
            phase_q  <= rp_pkg::DEC_BUSY;
          end
        rp_pkg::DEC_BUSY:
          if (!mapped || slv_ack)        // unmapped answers at once
          begin
            host.ack <= 1'b1;
            host.err <= !mapped || slv_err;
            phase_q  <= rp_pkg::DEC_DONE;
          end
        rp_pkg::DEC_DONE:
          if (!host_req)                 // host released, release the slave too
          begin
            host.ack <= 1'b0;
            host.err <= 1'b0;
            wen_q    <= 1'b0;
            ren_q    <= 1'b0;
            phase_q  <= rp_pkg::DEC_IDLE;
          end
        default: phase_q <= rp_pkg::DEC_IDLE;
      endcase
    end
  end

  // payload, no reset
  always_ff @(posedge adc_clk)
  begin
    if (accept)
    begin
      addr_q  <= host.addr;
      wdata_q <= host.wdata;
    end
    if (phase_q == rp_pkg::DEC_BUSY)
      host.rdata <= mapped ? slv_rdata : '0;  // zero on err
  end

endmodule

/* design/sys_bus_if.sv */
// register bus between the decoder and its slave blocks
// four-phase request/acknowledge, one of wen or ren at a time
// master drives address, data and request, slave drives rdata, ack and err
`timescale 1ns/1ns
`include "rp_defs.svh"

interface sys_bus_if;

  logic [`RP_ADDR_W-1:0] addr;   // word address, region in the top bits
  rp_pkg::bus_word_t     wdata;  // held with the request
  logic                  wen;    // write request
  logic                  ren;    // read request
  rp_pkg::bus_word_t     rdata;  // valid while ack is high
  logic                  ack;    // follows the request by one clock
  logic                  err;    // only together with ack

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and fail if the log shows the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module rp_tb \
  -o rp_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rp_sim > sim.log 2>&1
cat sim.log
! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log && exit 0 || exit 1

/* verification/rp_props.sv */
// handshake properties of the host register bus
// bound to rp_top below, watches the plain bus ports only
`timescale 1ns/1ns

module rp_props (
  input logic adc_clk,
  input logic rst_i,
  input logic bus_wen_i,
  input logic bus_ren_i,
  input logic bus_ack_o,
  input logic bus_err_o
);

  logic req;

  assign req = bus_wen_i | bus_ren_i;

  // ack only answers a pending request, seen the clock before it rose
  ack_needs_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    $rose(bus_ack_o) |-> $past(req))
    else $error("ack rose without a request");

  // err never travels alone
  err_has_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    bus_err_o |-> bus_ack_o)
    else $error("err without ack");

  // release, decoder drops ack one clock after the request
  ack_release: assert property (@(posedge adc_clk) disable iff (rst_i)
    $fell(req) |-> ##[0:2] !bus_ack_o)
    else $error("ack held after request fell");

  one_request: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(bus_wen_i && bus_ren_i))
    else $error("write and read requested together");

endmodule

bind rp_top rp_props props0 (
  .adc_clk   (adc_clk),
  .rst_i     (rst_i),
  .bus_wen_i (bus_wen_i),
  .bus_ren_i (bus_ren_i),
  .bus_ack_o (bus_ack_o),
  .bus_err_o (bus_err_o)
);

/* verification/rp_tb.sv */
// testbench of the two-channel fast analog path
// four-phase host bus tasks, random samples from a fixed seed and a
// cycle model of ADC conversion, P controller, limiter and DAC code
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_tb;

  logic        adc_clk = 1'b0;
  logic        rst_i = 1'b1;
  logic [15:0] adc_a_dat_i = '0;
  logic [15:0] adc_b_dat_i = '0;
  logic [19:0] bus_addr_i = '0;
  logic [31:0] bus_wdata_i = '0;
  logic        bus_wen_i = 1'b0;
  logic        bus_ren_i = 1'b0;
  logic [31:0] bus_rdata_o;
  logic        bus_ack_o;
  logic        bus_err_o;
  logic [13:0] dac_a_dat_o;
  logic [13:0] dac_b_dat_o;

  int          set_m [2];     // register copies
  int          gain_m [2];
  int          bias_m [2];
  int          min_m [2];
  int          max_m [2];
  logic [1:0]  rail_m [2];    // predicted sticky flags
  int          cyc = 0;       // rising edges since start
  int          ack_cyc;       // cycle where the last ack was seen
  logic [27:0] exp_q [$];     // expected codes, 4 deep

  rp_top dut0 (.*);

  always #2 adc_clk = ~adc_clk;
  always @(posedge adc_clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // checks and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("timed out waiting for %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  endtask

  function automatic int rand_signed(input int bits);
    logic [31:0] r;
    r = $urandom;
    return int'(r << (32 - bits)) >>> (32 - bits);
  endfunction

  // negative slope pin code, top 14 bits kept
  function automatic int adc_to_smp(input logic [15:0] raw);
    logic [13:0] c;
    c = raw[15:2];
    return int'($signed({c[13], ~c[12:0]}));
  endfunction

  function automatic logic [13:0] smp_to_dac(input int s);
    logic [13:0] v;
    v = s[13:0];
    return {v[13], ~v[12:0]};
  endfunction

  function automatic int p_sum(input int ch, input int s);
    return bias_m[ch] + (((set_m[ch] - s) * gain_m[ch]) >>> 8);
  endfunction

  function automatic int sat14(input int v);
    return (v > 8191) ? 8191 : ((v < -8192) ? -8192 : v);
  endfunction

  function automatic int limit(input int ch, input int v);
    int s;
    s = sat14(v);
    if (s > max_m[ch])
      return max_m[ch];
    if (s < min_m[ch])
      return min_m[ch];
    return s;
  endfunction

  function automatic logic [1:0] rail_hit(input int ch, input int v);
    int s;
    s = sat14(v);
    return (s > max_m[ch]) ? 2'b10 : ((s < min_m[ch]) ? 2'b01 : 2'b00);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // host bus, four-phase
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_xfer(input logic wr, input logic [19:0] addr, input logic [31:0] data,
                          output logic [31:0] rd, output logic err);
    int t;
    t = 0;
    while (bus_ack_o && t < 20)     // previous cycle fully released
    begin
      @(negedge adc_clk);
      t++;
    end
    if (bus_ack_o)
      give_up("idle bus");
    bus_addr_i  = addr;
    bus_wdata_i = data;
    bus_wen_i   = wr;
    bus_ren_i   = !wr;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
    end
    while (!bus_ack_o && t < 20);
    if (!bus_ack_o)
      give_up("bus ack");
    ack_cyc   = cyc;
    rd        = bus_rdata_o;
    err       = bus_err_o;
    bus_wen_i = 1'b0;
    bus_ren_i = 1'b0;
    t = 0;
    do
    begin
      @(negedge adc_clk);
      t++;
    end
    while (bus_ack_o && t < 20);
    if (bus_ack_o)
      give_up("ack release");
    check_eq("err after release", bus_err_o, 0);
  endtask

  task automatic bus_write(input int region, input int off, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b1, (region << 16) | off, data, rd, err);
    check_eq("write err", err, 0);
  endtask

  task automatic bus_read(input int region, input int off, output logic [31:0] data);
    logic err;
    bus_xfer(1'b0, (region << 16) | off, '0, data, err);
    check_eq("read err", err, 0);
  endtask

  task automatic set_ctrl(input int ch, input int set, input int gain, input int bias);
    set_m[ch]  = set;
    gain_m[ch] = gain;
    bias_m[ch] = bias;
    bus_write(`RP_REG_CTRL, `RP_CT_SET * 2 + ch, set);
    bus_write(`RP_REG_CTRL, `RP_CT_GAIN * 2 + ch, gain);
    bus_write(`RP_REG_CTRL, `RP_CT_BIAS * 2 + ch, bias);
  endtask

  task automatic set_limits(input int ch, input int lo, input int hi);
    min_m[ch] = lo;
    max_m[ch] = hi;
    bus_write(`RP_REG_LIM, `RP_LM_MIN * 2 + ch, lo);
    bus_write(`RP_REG_LIM, `RP_LM_MAX * 2 + ch, hi);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // datapath stream, loop off
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_stream(input int n);
    logic [27:0] e;
    int          s;
    int          v;
    exp_q.delete();
    for (int i = 0; i < n + 4; i++)
    begin
      @(negedge adc_clk);
      if (exp_q.size() == 4)        // sample from 4 clocks back
      begin
        e = exp_q.pop_front();
        check_eq("dac a", dac_a_dat_o, e[13:0]);
        check_eq("dac b", dac_b_dat_o, e[27:14]);
        s = int'($signed({dac_a_dat_o[13], ~dac_a_dat_o[12:0]}));
        check_eq("a inside limits", (s >= min_m[0]) && (s <= max_m[0]), 1);
        s = int'($signed({dac_b_dat_o[13], ~dac_b_dat_o[12:0]}));
        check_eq("b inside limits", (s >= min_m[1]) && (s <= max_m[1]), 1);
      end
      if (i < n)
      begin
        adc_a_dat_i = $urandom;
        adc_b_dat_i = $urandom;
      end
      for (int ch = 0; ch < 2; ch++)
      begin
        v = p_sum(ch, adc_to_smp(ch == 0 ? adc_a_dat_i : adc_b_dat_i));
        rail_m[ch] |= rail_hit(ch, v);
        e[14*ch +: 14] = smp_to_dac(limit(ch, v));
      end
      exp_q.push_back(e);
    end
  endtask

  // flags the held input raises right after a clear
  task automatic clear_rails();
    bus_write(`RP_REG_LIM, `RP_LM_RAIL, $urandom);
    rail_m[0] = rail_hit(0, p_sum(0, adc_to_smp(adc_a_dat_i)));
    rail_m[1] = rail_hit(1, p_sum(1, adc_to_smp(adc_b_dat_i)));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    logic        err;
    int          off;
    int          v;
    int          st_c [2];
    int          st_l [2];
    logic [13:0] st_d [2];
    int          nc;
    void'($urandom(32'h2940_fe56));
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_i = 1'b0;

    // reset values
    check_eq("ack after reset", bus_ack_o, 0);
    check_eq("err after reset", bus_err_o, 0);
    check_eq("dac a reset", dac_a_dat_o, 14'h1fff);
    check_eq("dac b reset", dac_b_dat_o, 14'h1fff);
    bus_read(`RP_REG_HK, `RP_HK_ID, rd);
    check_eq("id", rd, `RP_ID_VALUE);
    bus_read(`RP_REG_CTRL, `RP_CT_GAIN * 2 + 1, rd);
    check_eq("gain reset", rd, 0);
    bus_read(`RP_REG_LIM, `RP_LM_MIN * 2, rd);
    check_eq("min reset", rd, -8192);
    bus_read(`RP_REG_LIM, `RP_LM_MAX * 2 + 1, rd);
    check_eq("max reset", rd, 8191);

    // write/read pairs, signed fields come back extended
    for (int i = 0; i < 24; i++)
    begin
      if (i % 2)
      begin
        off = $urandom % 4;
        v   = rand_signed(14);
        bus_write(`RP_REG_LIM, off, v);
        bus_read(`RP_REG_LIM, off, rd);
      end
      else
      begin
        off = $urandom % 6;
        v   = (off / 2 == `RP_CT_GAIN) ? rand_signed(16) : rand_signed(14);
        bus_write(`RP_REG_CTRL, off, v);
        bus_read(`RP_REG_CTRL, off, rd);
      end
      check_eq("readback", rd, v);
    end
    bus_xfer(1'b0, ((3 + $urandom % 13) << 16) | ($urandom % 16), '0, rd, err);
    check_eq("unmapped err", err, 1);
    check_eq("unmapped data", rd, 0);

    // ADC to DAC with wide limits
    for (int ch = 0; ch < 2; ch++)
    begin
      set_limits(ch, -8192, 8191);
      set_ctrl(ch, rand_signed(14), rand_signed(16), rand_signed(14));
    end
    run_stream(200);

    // narrow limits and railed flags
    for (int ch = 0; ch < 2; ch++)
    begin
      v = -int'($urandom % 3000);
      set_limits(ch, v, v + 1 + int'($urandom % 3000));
      set_ctrl(ch, rand_signed(14), rand_signed(12), rand_signed(13));
    end
    clear_rails();
    run_stream(64);
    bus_read(`RP_REG_LIM, `RP_LM_RAIL, rd);
    check_eq("rail flags", rd, {rail_m[1], rail_m[0]});
    clear_rails();
    bus_read(`RP_REG_LIM, `RP_LM_RAIL, rd);
    check_eq("rail after clear", rd, {rail_m[1], rail_m[0]});

    // loop on, gain 0 gives the clamped bias
    set_ctrl(0, rand_signed(14), 0, rand_signed(14));
    set_ctrl(1, rand_signed(14), 0, rand_signed(14));
    bus_write(`RP_REG_HK, `RP_HK_LOOP, 1);
    for (int i = 0; i < 16; i++)
    begin
      @(negedge adc_clk);
      adc_a_dat_i = $urandom;
      adc_b_dat_i = $urandom;
      if (i >= 6)
      begin
        check_eq("loop bias a", dac_a_dat_o, smp_to_dac(limit(0, bias_m[0])));
        check_eq("loop bias b", dac_b_dat_o, smp_to_dac(limit(1, bias_m[1])));
      end
    end

    // loop on with gain, steady state with loop off first
    bus_write(`RP_REG_HK, `RP_HK_LOOP, 0);
    for (int ch = 0; ch < 2; ch++)
      set_ctrl(ch, rand_signed(13), rand_signed(10), rand_signed(13));
    repeat (6) @(negedge adc_clk);
    for (int ch = 0; ch < 2; ch++)
    begin
      st_c[ch] = p_sum(ch, adc_to_smp(ch == 0 ? adc_a_dat_i : adc_b_dat_i));
      st_l[ch] = limit(ch, st_c[ch]);
      st_d[ch] = smp_to_dac(st_l[ch]);
    end
    bus_write(`RP_REG_HK, `RP_HK_LOOP, 1);
    nc = 1 + cyc - ack_cyc;       // edges with the loop closed so far
    for (int i = 0; i < nc + 40; i++)
    begin
      if (i >= nc)
      begin
        @(negedge adc_clk);
        adc_a_dat_i = $urandom;
        adc_b_dat_i = $urandom;
      end
      for (int ch = 0; ch < 2; ch++)
      begin
        st_d[ch] = smp_to_dac(st_l[ch]);
        v        = st_c[ch];
        st_c[ch] = p_sum(ch, st_l[ch]);   // controller sees the old limiter value
        st_l[ch] = limit(ch, v);
      end
      if (i >= nc)
      begin
        check_eq("loop a", dac_a_dat_o, st_d[0]);
        check_eq("loop b", dac_b_dat_o, st_d[1]);
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/rp_pkg.sv
design/sys_bus_if.sv
design/sys_bus_decoder.sv
design/rp_housekeeping.sv
design/rp_adc_front.sv
design/rp_p_ctrl.sv
design/rp_out_stage.sv
design/rp_top.sv
verification/rp_props.sv
verification/rp_tb.sv
